// File: hw/cam_binarizer.sv
`timescale 1ns/1ps
`default_nettype none

module cam_binarizer import digit_overlay_pkg::*; (
    input  logic                 video_clk,
    input  logic                 rst_n,
    input  logic                 cam_vsync,  // frame blank, active high
    input  logic                 cam_href,   // line active
    input  logic                 cam_valid,  // pixel strobe
    input  pixel_t               cam_data,   // rgb565 word
    output logic [GRID_BITS-1:0] bin_img     // latched binary image
);

    logic [9:0]           col_cnt;           // camera column, 240 max
    logic [9:0]           row_cnt;           // camera line
    logic                 href_d;            // for falling edge detect
    logic                 href_fall;
    logic [7:0]           chan_sum;          // r + g + b fields
    logic                 pix_bit;           // 1 = dark sample
    logic                 col_hit;
    logic                 row_hit;
    logic                 take_sample;
    logic [GRID_BITS-1:0] bin_shr;           // image under construction

    // ----------------------------------------------------------------------
    // camera position
    // ----------------------------------------------------------------------
    assign href_fall = href_d && !cam_href;

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            href_d  <= 1'b0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else begin
            href_d <= cam_href;

            if (!cam_href) begin
                col_cnt <= '0;               // between lines
            end else if (cam_valid) begin
                col_cnt <= col_cnt + 1'b1;
            end

            if (cam_vsync) begin
                row_cnt <= '0;               // new frame
            end else if (href_fall) begin
                row_cnt <= row_cnt + 1'b1;   // line done
            end
        end
    end

    // ----------------------------------------------------------------------
    // decimation and threshold
    // ----------------------------------------------------------------------
    // grid point when low bits are zero and the quotient stays inside 28
    assign col_hit = (col_cnt[CAM_DECIM_SHIFT-1:0] == '0) &&
                     ((col_cnt >> CAM_DECIM_SHIFT) < 10'(GRID_SIZE));
    assign row_hit = (row_cnt[CAM_DECIM_SHIFT-1:0] == '0) &&
                     ((row_cnt >> CAM_DECIM_SHIFT) < 10'(GRID_SIZE));

    assign take_sample = cam_href && cam_valid && col_hit && row_hit;

    // plain field sum, green is not rescaled
    assign chan_sum = 8'(cam_data[15:11]) + 8'(cam_data[10:5]) + 8'(cam_data[4:0]);
    assign pix_bit  = (chan_sum < 8'(BIN_THRESHOLD));

    // ----------------------------------------------------------------------
    // shift register and frame latch
    // ----------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            bin_shr <= '0;
            bin_img <= '0;
        end else begin
            if (take_sample) begin
                // new bit at the top, first sample ends in bit 0
                bin_shr <= {pix_bit, bin_shr[GRID_BITS-1:1]};
            end
            if (cam_vsync) begin
                bin_img <= bin_shr;          // stable copy for the display
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/digit_overlay_pkg.sv
`default_nettype none

package digit_overlay_pkg;

    // ----------------------------------------------------------------------
    // display mode
    // ----------------------------------------------------------------------
    localparam int H_ACTIVE = 160;           // visible pixels per line
    localparam int H_FRONT  = 8;             // front porch, pixels
    localparam int H_SYNC   = 16;            // hs pulse width
    localparam int H_TOTAL  = 200;           // full line incl. back porch

    localparam int V_ACTIVE = 120;           // visible lines
    localparam int V_FRONT  = 4;             // front porch, lines
    localparam int V_SYNC   = 4;             // vs pulse width
    localparam int V_TOTAL  = 140;           // full frame

    // ----------------------------------------------------------------------
    // camera sampling grid
    // ----------------------------------------------------------------------
    localparam int GRID_SIZE       = 28;     // image side in cells
    localparam int GRID_BITS       = 784;    // 28 x 28
    localparam int CAM_DECIM_SHIFT = 3;      // every 8th pixel and line
    localparam int BIN_THRESHOLD   = 30;     // dark when r+g+b below this

    // ----------------------------------------------------------------------
    // overlay placement
    // ----------------------------------------------------------------------
    localparam int CELL_SHIFT  = 2;          // image cell is 4x4 pixels
    localparam int BIN_X0      = 8;          // image origin, in image cells
    localparam int BIN_Y0      = 2;
    localparam int CLASS_SHIFT = 3;          // class cell is 8x8 pixels
    localparam int CLASS_X0    = 8;          // bar origin, in class cells
    localparam int CLASS_Y0    = 13;
    localparam int NUM_CLASSES = 10;         // digits 0..9
    localparam int COORD_W     = 8;          // raster x/y width

    typedef logic [15:0]        pixel_t;     // rgb565, r in [15:11]
    typedef logic [COORD_W-1:0] coord_t;

    // source of the current output pixel
    typedef enum logic [1:0] {
        REGION_NONE  = 2'd0,                 // blanking
        REGION_BIN   = 2'd1,                 // magnified binary image
        REGION_CLASS = 2'd2,                 // class indicator bar
        REGION_BACK  = 2'd3                  // gradient background
    } region_e;

endpackage

`default_nettype wire

// File: hw/digit_overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

module digit_overlay_top import digit_overlay_pkg::*; (
    input  logic                   video_clk,
    input  logic                   rst_n,
    // camera side, words already merged
    input  logic                   cam_vsync,
    input  logic                   cam_href,
    input  logic                   cam_valid,
    input  pixel_t                 cam_data,
    // classifier result
    input  logic [NUM_CLASSES-1:0] class_vec,
    // display side
    output logic                   vid_hs,
    output logic                   vid_vs,
    output logic                   vid_de,
    output logic [7:0]             vid_r,
    output logic [7:0]             vid_g,
    output logic [7:0]             vid_b
);

    logic [GRID_BITS-1:0] bin_img;           // latched 28x28 image

    raster_if rast ();                       // timing to renderer

    // ----------------------------------------------------------------------
    // display raster
    // ----------------------------------------------------------------------
    video_timing video_timing_inst (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .rast      (rast.src)
    );

    // ----------------------------------------------------------------------
    // camera sampling
    // ----------------------------------------------------------------------
    cam_binarizer cam_binarizer_inst (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_valid (cam_valid),
        .cam_data  (cam_data),
        .bin_img   (bin_img)
    );

    // ----------------------------------------------------------------------
    // overlay, two cycles behind the raster
    // ----------------------------------------------------------------------
    overlay_renderer overlay_renderer_inst (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .rast      (rast.dst),
        .bin_img   (bin_img),
        .class_vec (class_vec),
        .vid_hs    (vid_hs),
        .vid_vs    (vid_vs),
        .vid_de    (vid_de),
        .vid_r     (vid_r),
        .vid_g     (vid_g),
        .vid_b     (vid_b)
    );

endmodule

`default_nettype wire

// File: hw/overlay_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_renderer import digit_overlay_pkg::*; (
    input  logic                   video_clk,
    input  logic                   rst_n,
    raster_if.dst                  rast,
    input  logic [GRID_BITS-1:0]   bin_img,   // row*28+col per cell
    input  logic [NUM_CLASSES-1:0] class_vec, // one-hot-ish classifier result
    output logic                   vid_hs,
    output logic                   vid_vs,
    output logic                   vid_de,
    output logic [7:0]             vid_r,
    output logic [7:0]             vid_g,
    output logic [7:0]             vid_b
);

    coord_t  cell_x;                         // image cell column
    coord_t  cell_y;
    coord_t  ccell_x;                        // class cell column
    coord_t  ccell_y;
    coord_t  bin_col;                        // cell inside the image
    coord_t  bin_row;
    logic    in_bin;
    logic    in_cls;
    logic [9:0] img_idx;                     // 784 cells fit 10 bits
    logic [3:0] cls_idx;                     // 0..9
    region_e region_d;
    logic    bit_d;

    region_e region_q;                       // stage one results
    logic    bit_q;
    coord_t  x_q;
    coord_t  y_q;
    logic    hs_q;
    logic    vs_q;
    logic    de_q;

    // ----------------------------------------------------------------------
    // region lookup
    // ----------------------------------------------------------------------
    assign cell_x  = rast.x >> CELL_SHIFT;
    assign cell_y  = rast.y >> CELL_SHIFT;
    assign ccell_x = rast.x >> CLASS_SHIFT;
    assign ccell_y = rast.y >> CLASS_SHIFT;

    assign in_bin = (cell_x >= COORD_W'(BIN_X0)) &&
                    (cell_x <  COORD_W'(BIN_X0 + GRID_SIZE)) &&
                    (cell_y >= COORD_W'(BIN_Y0)) &&
                    (cell_y <  COORD_W'(BIN_Y0 + GRID_SIZE));

    assign in_cls = (ccell_x >= COORD_W'(CLASS_X0)) &&
                    (ccell_x <  COORD_W'(CLASS_X0 + NUM_CLASSES)) &&
                    (ccell_y == COORD_W'(CLASS_Y0));   // single row bar

    assign bin_col = cell_x - COORD_W'(BIN_X0);
    assign bin_row = cell_y - COORD_W'(BIN_Y0);
    assign img_idx = 10'(bin_row) * 10'(GRID_SIZE) + 10'(bin_col);
    assign cls_idx = 4'(ccell_x - COORD_W'(CLASS_X0));

    // image wins over the bar, bar over the background
    always_comb begin
        region_d = REGION_NONE;
        bit_d    = 1'b0;
        if (rast.de) begin
            if (in_bin) begin
                region_d = REGION_BIN;
                bit_d    = bin_img[img_idx];
            end else if (in_cls) begin
                region_d = REGION_CLASS;
                bit_d    = class_vec[cls_idx];
            end else begin
                region_d = REGION_BACK;
            end
        end
    end

    // ----------------------------------------------------------------------
    // stage one
    // ----------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            region_q <= REGION_NONE;
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
            de_q     <= 1'b0;
        end else begin
            region_q <= region_d;
            hs_q     <= rast.hs;
            vs_q     <= rast.vs;
            de_q     <= rast.de;
        end
    end

    always_ff @(posedge video_clk) begin
        bit_q <= bit_d;                      // fetched image or class bit
        x_q   <= rast.x;                     // for the gradient
        y_q   <= rast.y;
    end

    // ----------------------------------------------------------------------
    // stage two, colour and aligned sync
    // ----------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            vid_hs <= 1'b0;
            vid_vs <= 1'b0;
            vid_de <= 1'b0;
            vid_r  <= '0;
            vid_g  <= '0;
            vid_b  <= '0;
        end else begin
            vid_hs <= hs_q;
            vid_vs <= vs_q;
            vid_de <= de_q;
            case (region_q)
                REGION_BIN, REGION_CLASS: begin
                    vid_r <= {8{bit_q}};     // white or black
                    vid_g <= {8{bit_q}};
                    vid_b <= {8{bit_q}};
                end
                REGION_BACK: begin
                    vid_r <= x_q;            // horizontal ramp
                    vid_g <= y_q;            // vertical ramp
                    vid_b <= 8'hff;
                end
                default: begin
                    vid_r <= '0;             // blanking stays black
                    vid_g <= '0;
                    vid_b <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/raster_if.sv
`timescale 1ns/1ps
`default_nettype none

// free running raster, one position per video_clk
interface raster_if import digit_overlay_pkg::*; ();

    logic   hs;                              // horizontal sync, active high
    logic   vs;                              // vertical sync, active high
    logic   de;                              // active area
    coord_t x;                               // pixel column
    coord_t y;                               // line number

    modport src (
        output hs, vs, de, x, y
    );

    modport dst (
        input  hs, vs, de, x, y
    );

endinterface

`default_nettype wire

// File: hw/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing import digit_overlay_pkg::*; (
    input  logic      video_clk,
    input  logic      rst_n,
    raster_if.src     rast
);

    coord_t h_cnt;                           // 0 .. H_TOTAL-1
    coord_t v_cnt;                           // 0 .. V_TOTAL-1
    logic   h_last;                          // last pixel of a line
    logic   v_last;                          // last line of a frame
    logic   hs_nxt;
    logic   vs_nxt;
    logic   de_nxt;

    // ----------------------------------------------------------------------
    // counters
    // ----------------------------------------------------------------------
    assign h_last = (h_cnt == COORD_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == COORD_W'(V_TOTAL - 1));

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;                 // wrap line
                if (v_last) begin
                    v_cnt <= '0;             // wrap frame
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // sync decode
    // ----------------------------------------------------------------------
    // sync pulse sits right after the front porch, back porch fills the rest
    assign hs_nxt = (h_cnt >= COORD_W'(H_ACTIVE + H_FRONT)) &&
                    (h_cnt <  COORD_W'(H_ACTIVE + H_FRONT + H_SYNC));
    assign vs_nxt = (v_cnt >= COORD_W'(V_ACTIVE + V_FRONT)) &&
                    (v_cnt <  COORD_W'(V_ACTIVE + V_FRONT + V_SYNC));
    assign de_nxt = (h_cnt <  COORD_W'(H_ACTIVE)) &&
                    (v_cnt <  COORD_W'(V_ACTIVE));

    // registered outputs, coordinates travel with their sync
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            rast.hs <= 1'b0;
            rast.vs <= 1'b0;
            rast.de <= 1'b0;
            rast.x  <= '0;
            rast.y  <= '0;
        end else begin
            rast.hs <= hs_nxt;
            rast.vs <= vs_nxt;
            rast.de <= de_nxt;
            rast.x  <= h_cnt;                // same position as the sync flags
            rast.y  <= v_cnt;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
    --top-module tb_digit_overlay \
    -f tb.f -o sim_tb \
    && { ./obj_dir/sim_tb > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb.f
hw/digit_overlay_pkg.sv
hw/raster_if.sv
hw/video_timing.sv
hw/cam_binarizer.sv
hw/overlay_renderer.sv
hw/digit_overlay_top.sv
tb/digit_overlay_assertions.sv
tb/tb_digit_overlay.sv

// File: tb/digit_overlay_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module digit_overlay_assertions import digit_overlay_pkg::*; (
    input logic       video_clk,
    input logic       rst_n,
    input logic       vid_hs,
    input logic       vid_vs,
    input logic       vid_de,
    input logic [7:0] vid_r,
    input logic [7:0] vid_g,
    input logic [7:0] vid_b
);

    int hs_len;                                    // cycles of the current hs pulse

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_len <= 0;
        end else if (vid_hs) begin
            hs_len <= hs_len + 1;
        end else begin
            hs_len <= 0;
        end
    end

    // active video never starts inside vertical sync
    de_outside_vsync: assert property (@(posedge video_clk) disable iff (!rst_n)
        $rose(vid_de) |-> !vid_vs)
        else $error("vid_de rose while vid_vs was high");

    // on the falling edge the counter holds the full pulse length
    hs_pulse_width: assert property (@(posedge video_clk) disable iff (!rst_n)
        $fell(vid_hs) |-> (hs_len == H_SYNC))
        else $error("vid_hs pulse was %0d cycles long", hs_len);

    blank_is_black: assert property (@(posedge video_clk) disable iff (!rst_n)
        !vid_de |-> (vid_r == 8'h00 && vid_g == 8'h00 && vid_b == 8'h00))
        else $error("colour not zero while vid_de is low");

endmodule

bind overlay_renderer digit_overlay_assertions overlay_checks_inst (
    .video_clk (video_clk),
    .rst_n     (rst_n),
    .vid_hs    (vid_hs),
    .vid_vs    (vid_vs),
    .vid_de    (vid_de),
    .vid_r     (vid_r),
    .vid_g     (vid_g),
    .vid_b     (vid_b)
);

`default_nettype wire

// File: tb/tb_digit_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module tb_digit_overlay import digit_overlay_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;         // ns
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] RNG_SEED     = 32'hd624_aacf;
    localparam int          CAM_LINES    = 240;        // camera frame height
    localparam int          CAM_PIXELS   = 240;        // camera line width
    localparam int          LINE_GAP     = 16;         // href low between lines
    localparam int          VSYNC_LEN    = 12;
    localparam int          VSYNC_GAP    = 24;         // quiet time after vsync
    localparam int          NUM_FRAMES   = 3;
    localparam pixel_t      DARK_MASK    = 16'h39e7;   // r+g+b stays below 30
    // one register in the timing generator plus the two renderer stages
    localparam int          OUT_DELAY    = 3;
    // worst case assumes every pixel costs two cycles
    localparam int          FRAME_MAX    = VSYNC_LEN + VSYNC_GAP +
                                           CAM_LINES * (2 * CAM_PIXELS + LINE_GAP);
    localparam int          WATCHDOG_CYCLES = (NUM_FRAMES + 1) * FRAME_MAX +
                                              2 * H_TOTAL * V_TOTAL + RESET_CYCLES;

    logic                   video_clk;
    logic                   rst_n;
    logic                   cam_vsync;
    logic                   cam_href;
    logic                   cam_valid;
    pixel_t                 cam_data;
    logic [NUM_CLASSES-1:0] class_vec;
    logic                   vid_hs;
    logic                   vid_vs;
    logic                   vid_de;
    logic [7:0]             vid_r;
    logic [7:0]             vid_g;
    logic [7:0]             vid_b;

    logic [31:0]            rng_state;
    int                     err_cnt;
    int                     edges;                 // active clock edges since reset
    logic [9:0]             m_col;                 // model camera column
    logic [9:0]             m_row;
    logic                   m_href_d;
    logic [GRID_BITS-1:0]   m_shr;                 // model shift register
    logic [GRID_BITS-1:0]   m_img;                 // model latched image
    logic [GRID_BITS-1:0]   img_d1;
    logic [GRID_BITS-1:0]   img_d2;                // image as seen by the output pixel
    logic [NUM_CLASSES-1:0] cls_d1;
    logic [NUM_CLASSES-1:0] cls_d2;
    logic                   exp_hs;
    logic                   exp_vs;
    logic                   exp_de;
    logic [7:0]             exp_r;
    logic [7:0]             exp_g;
    logic [7:0]             exp_b;

    digit_overlay_top digit_overlay_top_inst (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_valid (cam_valid),
        .cam_data  (cam_data),
        .class_vec (class_vec),
        .vid_hs    (vid_hs),
        .vid_vs    (vid_vs),
        .vid_de    (vid_de),
        .vid_r     (vid_r),
        .vid_g     (vid_g),
        .vid_b     (vid_b)
    );

    initial begin
        video_clk = 1'b0;
        forever #(CLK_PERIOD / 2) video_clk = ~video_clk;
    end

    // ----------------------------------------------------------------------
    // random numbers and stimulus
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    task automatic draw_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r         = rng_state;
    endtask

    // vsync pulse, new classifier result with each camera frame
    task automatic send_vsync();
        logic [31:0] r;
        draw_rand(r);
        @(posedge video_clk);
        cam_vsync <= 1'b1;
        class_vec <= r[NUM_CLASSES-1:0];
        repeat (VSYNC_LEN) @(posedge video_clk);
        cam_vsync <= 1'b0;
        repeat (VSYNC_GAP) @(posedge video_clk);
    endtask

    task automatic send_frame();
        int          line;
        int          pix;
        logic [31:0] r;
        send_vsync();
        for (line = 0; line < CAM_LINES; line++) begin
            pix = 0;
            while (pix < CAM_PIXELS) begin
                draw_rand(r);
                @(posedge video_clk);
                cam_href <= 1'b1;
                if (r[1:0] != 2'b00) begin                 // about 3 in 4 cycles carry a pixel
                    cam_valid <= 1'b1;
                    cam_data  <= r[18] ? (r[17:2] & DARK_MASK) : r[17:2];
                    pix++;
                end else begin
                    cam_valid <= 1'b0;
                    cam_data  <= r[17:2];                   // junk, must be ignored
                end
            end
            @(posedge video_clk);
            cam_href  <= 1'b0;
            cam_valid <= 1'b0;
            repeat (LINE_GAP - 1) @(posedge video_clk);
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic logic is_grid_point(input logic [9:0] n);
        int v;
        v = int'(n);
        return (v % (1 << CAM_DECIM_SHIFT) == 0) && (v / (1 << CAM_DECIM_SHIFT) < GRID_SIZE);
    endfunction

    function automatic logic dark_pixel(input pixel_t p);
        int sum;
        sum = int'(p[15:11]) + int'(p[10:5]) + int'(p[4:0]);
        return (sum < BIN_THRESHOLD);
    endfunction

    always @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            edges    <= 0;
            m_col    <= '0;
            m_row    <= '0;
            m_href_d <= 1'b0;
            m_shr    <= '0;
            m_img    <= '0;
            img_d1   <= '0;
            img_d2   <= '0;
            cls_d1   <= '0;
            cls_d2   <= '0;
        end else begin
            edges    <= edges + 1;
            m_href_d <= cam_href;
            if (!cam_href) begin
                m_col <= '0;
            end else if (cam_valid) begin
                m_col <= m_col + 10'd1;
            end
            if (cam_vsync) begin
                m_row <= '0;
            end else if (m_href_d && !cam_href) begin
                m_row <= m_row + 10'd1;                     // end of a camera line
            end
            if (cam_href && cam_valid && is_grid_point(m_col) && is_grid_point(m_row)) begin
                m_shr <= {dark_pixel(cam_data), m_shr[GRID_BITS-1:1]};
            end
            if (cam_vsync) begin
                m_img <= m_shr;
            end
            img_d1 <= m_img;                               // renderer stage one sample
            img_d2 <= img_d1;
            cls_d1 <= class_vec;
            cls_d2 <= cls_d1;
        end
    end

    task automatic compute_expected();
        int   p;
        int   x;
        int   y;
        int   cx;
        int   cy;
        logic bit_v;
        exp_hs = 1'b0;
        exp_vs = 1'b0;
        exp_de = 1'b0;
        exp_r  = 8'h00;
        exp_g  = 8'h00;
        exp_b  = 8'h00;
        if (edges >= OUT_DELAY) begin
            p      = edges - OUT_DELAY;                    // raster position on the output
            x      = p % H_TOTAL;
            y      = (p / H_TOTAL) % V_TOTAL;
            exp_hs = (x >= H_ACTIVE + H_FRONT) && (x < H_ACTIVE + H_FRONT + H_SYNC);
            exp_vs = (y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC);
            exp_de = (x < H_ACTIVE) && (y < V_ACTIVE);
            if (exp_de) begin
                cx = x >> CELL_SHIFT;
                cy = y >> CELL_SHIFT;
                if (cx >= BIN_X0 && cx < BIN_X0 + GRID_SIZE &&
                    cy >= BIN_Y0 && cy < BIN_Y0 + GRID_SIZE) begin
                    bit_v = img_d2[(cy - BIN_Y0) * GRID_SIZE + (cx - BIN_X0)];
                    exp_r = {8{bit_v}};
                    exp_g = {8{bit_v}};
                    exp_b = {8{bit_v}};
                end else if ((x >> CLASS_SHIFT) >= CLASS_X0 &&
                             (x >> CLASS_SHIFT) <  CLASS_X0 + NUM_CLASSES &&
                             (y >> CLASS_SHIFT) == CLASS_Y0) begin
                    bit_v = cls_d2[(x >> CLASS_SHIFT) - CLASS_X0];
                    exp_r = {8{bit_v}};
                    exp_g = {8{bit_v}};
                    exp_b = {8{bit_v}};
                end else begin
                    exp_r = 8'(x);                          // gradient background
                    exp_g = 8'(y);
                    exp_b = 8'hff;
                end
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [GRID_BITS-1:0] got,
                                   input logic [GRID_BITS-1:0] want);
        err_cnt++;
        $display("FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first mismatch");
    endtask

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge video_clk) begin
        compute_expected();
        assert (vid_hs === exp_hs)
            else report_mismatch("vid_hs", GRID_BITS'(vid_hs), GRID_BITS'(exp_hs));
        assert (vid_vs === exp_vs)
            else report_mismatch("vid_vs", GRID_BITS'(vid_vs), GRID_BITS'(exp_vs));
        assert (vid_de === exp_de)
            else report_mismatch("vid_de", GRID_BITS'(vid_de), GRID_BITS'(exp_de));
        assert (vid_r === exp_r)
            else report_mismatch("vid_r", GRID_BITS'(vid_r), GRID_BITS'(exp_r));
        assert (vid_g === exp_g)
            else report_mismatch("vid_g", GRID_BITS'(vid_g), GRID_BITS'(exp_g));
        assert (vid_b === exp_b)
            else report_mismatch("vid_b", GRID_BITS'(vid_b), GRID_BITS'(exp_b));
        // latched image only moves during camera vsync
        assert (digit_overlay_top_inst.bin_img === m_img)
            else report_mismatch("bin_img", digit_overlay_top_inst.bin_img, m_img);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge video_clk);
        $display("timeout, the camera frames did not complete in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_valid = 1'b0;
        cam_data  = '0;
        class_vec = '0;
        rng_state = RNG_SEED;
        err_cnt   = 0;
        repeat (RESET_CYCLES) @(posedge video_clk);
        rst_n <= 1'b1;
        repeat (NUM_FRAMES) send_frame();
        send_vsync();                                      // latch the last frame
        repeat (H_TOTAL * V_TOTAL) @(posedge video_clk);   // show it for one display frame
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "%0d mismatches", err_cnt);
        end
    end

endmodule

`default_nettype wire
